/* all.f */
+incdir+.
cond_pkg.sv
spi_reg_pkg.sv
spi_control_port.sv
test_pattern.sv
accum_cap_sequencer.sv
cond_source_select.sv
dmm_ctrl_top.sv
tb_dmm_ctrl.sv

/* tb_dmm_ctrl.sv */
////////////////////////////////////////
// testbench for dmm_ctrl_top, accum phase cut to 16 clk
// spi master holds each sck level for 8 clk
// stops at the first failed check
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_dmm_ctrl;

  localparam int ACCUM_CYCLES = 16;
  localparam int SCK_HOLD     = 8;
  localparam int RUN_TIMEOUT  = 200;

  logic        clk;
  logic        reset;
  logic        spi_sck;
  logic        spi_cs_n;
  logic        spi_cs2_n;
  logic        spi_mosi;
  logic        spi_miso;
  logic        u1004_4094_data;
  logic        glb_4094_clk;
  logic        glb_4094_data;
  logic        glb_4094_strobe;
  logic        oe_4094;
  logic [7:0]  mon;
  logic        led0;
  logic        sig_pc_sw_ctl;
  logic [3:0]  u402_ctl;
  logic [3:0]  u413_ctl;
  logic [3:0]  u414_ctl;

  // pins packed in cond_out_t order, monitor at the msb
  logic [21:0] cond_vec;
  logic [21:0] vec_prev;
  logic [21:0] vec_next;
  logic [7:0]  mon_prev;
  logic [7:0]  mon_next;
  // spi pins delayed to line up with the dut synchronizer
  logic        sck_d1;
  logic        sck_d2;
  logic        mosi_d1;
  logic        mosi_d2;
  logic [31:0] lcg_state;

  // check enables, changed only between clk edges
  logic        chk_pattern;
  logic        chk_off;
  logic        chk_counter;
  logic        chk_accum;
  logic        chk_route_on;
  logic        chk_route_off;

  dmm_ctrl_top #(
    .ACCUM_PHASE_CYCLES (ACCUM_CYCLES)
  ) dut (
    .clk             (clk),
    .reset           (reset),
    .spi_sck         (spi_sck),
    .spi_cs_n        (spi_cs_n),
    .spi_cs2_n       (spi_cs2_n),
    .spi_mosi        (spi_mosi),
    .spi_miso        (spi_miso),
    .u1004_4094_data (u1004_4094_data),
    .glb_4094_clk    (glb_4094_clk),
    .glb_4094_data   (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe),
    .oe_4094         (oe_4094),
    .mon             (mon),
    .led0            (led0),
    .sig_pc_sw_ctl   (sig_pc_sw_ctl),
    .u402_ctl        (u402_ctl),
    .u413_ctl        (u413_ctl),
    .u414_ctl        (u414_ctl)
  );

  // 4 ns period
  always #2 clk = ~clk;

  assign cond_vec = {mon, led0, sig_pc_sw_ctl, u402_ctl, u413_ctl, u414_ctl};
  assign mon_next = mon_prev + 8'd1;
  assign vec_next = vec_prev + 22'd1;

  always @(posedge clk)
  begin
    mon_prev <= mon;
    vec_prev <= cond_vec;
    sck_d1   <= spi_sck;
    sck_d2   <= sck_d1;
    mosi_d1  <= spi_mosi;
    mosi_d2  <= mosi_d1;
  end

  ////////////////////////////////////////
  // failure reporting and helpers

  task automatic text_error(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    text_error($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // numerical recipes lcg, upper bits used as data
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // n clk edges, then 1 ns so drives never race the edge
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // one full mode 0 frame, miso taken on sck rise of the 24 data bits
  task automatic spi_transfer(input spi_reg_pkg::spi_frame_t frame,
                              output logic [23:0] rd_data);
    logic [31:0] bits;
    bits     = frame;
    rd_data  = '0;
    spi_cs_n = 1'b0;
    tick(SCK_HOLD);
    for (int i = 31; i >= 0; i--)
    begin
      spi_mosi = bits[i];
      tick(SCK_HOLD);
      spi_sck = 1'b1;
      if (i < 24)
        rd_data = {rd_data[22:0], spi_miso};
      tick(SCK_HOLD);
      spi_sck = 1'b0;
    end
    tick(SCK_HOLD);
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    // register write lands 4 clk after the sampled cs rise
    tick(8);
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [23:0] data);
    spi_reg_pkg::spi_frame_t frame;
    logic [23:0]             unused;
    frame.read_only = 1'b0;
    frame.addr      = addr;
    frame.data      = data;
    spi_transfer(frame, unused);
  endtask

  // data bits of a read frame go out but must not be written
  task automatic read_reg(input logic [6:0] addr, input logic [23:0] junk,
                          output logic [23:0] rd_data);
    spi_reg_pkg::spi_frame_t frame;
    frame.read_only = 1'b1;
    frame.addr      = addr;
    frame.data      = junk;
    spi_transfer(frame, rd_data);
  endtask

  // length of the u402 run that holds at the current sample
  task automatic measure_run(output int len, output logic [3:0] code);
    code = u402_ctl;
    len  = 0;
    while (u402_ctl == code && len < RUN_TIMEOUT)
    begin
      tick(1);
      len++;
    end
    if (len >= RUN_TIMEOUT)
      text_error("u402_ctl stopped changing in accumulation cap mode");
  endtask

  // random levels on the chain pins, one change per clk
  task automatic drive_chain_pins(input int n);
    repeat (n)
    begin
      lcg_state       = lcg_next(lcg_state);
      spi_sck         = lcg_state[16];
      spi_mosi        = lcg_state[17];
      u1004_4094_data = lcg_state[18];
      tick(1);
    end
  endtask

  ////////////////////////////////////////
  // concurrent checks

  assert property (@(posedge clk) disable iff (reset) chk_pattern |-> mon == mon_next)
    else value_error("mon", $sampled(mon), $sampled(mon_next));
  // pc_sw and the three mux fields
  assert property (@(posedge clk) disable iff (reset) chk_pattern |-> cond_vec[12:0] == '0)
    else value_error("cond_vec[12:0]", $sampled(cond_vec[12:0]), 32'h0);
  assert property (@(posedge clk) disable iff (reset) chk_off |-> cond_vec == '0)
    else value_error("cond_vec", $sampled(cond_vec), 32'h0);
  assert property (@(posedge clk) disable iff (reset) chk_counter |-> cond_vec == vec_next)
    else value_error("cond_vec", $sampled(cond_vec), $sampled(vec_next));
  assert property (@(posedge clk) disable iff (reset) chk_accum |-> u413_ctl == 4'b1001)
    else value_error("u413_ctl", $sampled(u413_ctl), 32'h9);
  // only ground or dcv, so each change of u402 is a swap between the two
  assert property (@(posedge clk) disable iff (reset)
    chk_accum |-> (u402_ctl == 4'b1011 || u402_ctl == 4'b1000))
    else text_error($sformatf("u402_ctl holds 0x%0h, neither ground nor dcv",
                              $sampled(u402_ctl)));
  // led on only while the cap charges
  assert property (@(posedge clk) disable iff (reset)
    chk_accum |-> led0 == (u402_ctl == 4'b1000))
    else value_error("led0", $sampled(led0), $sampled(u402_ctl) == 4'b1000);
  assert property (@(posedge clk) disable iff (reset)
    chk_route_on |-> {glb_4094_clk, glb_4094_data} == {sck_d2, mosi_d2})
    else value_error("{glb_4094_clk,glb_4094_data}", $sampled({glb_4094_clk, glb_4094_data}),
                     $sampled({sck_d2, mosi_d2}));
  assert property (@(posedge clk) disable iff (reset)
    chk_route_on |-> {glb_4094_strobe, spi_miso} == {1'b1, u1004_4094_data})
    else value_error("{glb_4094_strobe,spi_miso}", $sampled({glb_4094_strobe, spi_miso}),
                     $sampled({1'b1, u1004_4094_data}));
  assert property (@(posedge clk) disable iff (reset)
    chk_route_off |-> {glb_4094_clk, glb_4094_data, glb_4094_strobe, spi_miso} == 4'b0000)
    else value_error("{glb_4094_clk,glb_4094_data,glb_4094_strobe,spi_miso}",
                     $sampled({glb_4094_clk, glb_4094_data, glb_4094_strobe, spi_miso}), 32'h0);

  ////////////////////////////////////////
  // stimulus

  initial
  begin
    logic [23:0] wr_data;
    logic [23:0] rd_data;
    logic [3:0]  code;
    int          run_len;

    clk             = 1'b0;
    reset           = 1'b1;
    spi_sck         = 1'b0;
    spi_cs_n        = 1'b1;
    spi_cs2_n       = 1'b1;
    spi_mosi        = 1'b0;
    u1004_4094_data = 1'b0;
    chk_pattern     = 1'b0;
    chk_off         = 1'b0;
    chk_counter     = 1'b0;
    chk_accum       = 1'b0;
    chk_route_on    = 1'b0;
    chk_route_off   = 1'b0;
    lcg_state       = 32'd72;
    wr_data         = '0;
    tick(2);
    reset = 1'b0;

    // idle outputs, then the monitor count across a wrap
    assert ({glb_4094_clk, glb_4094_data, glb_4094_strobe, oe_4094, spi_miso} == 5'b0)
      else value_error("4094 lines, oe_4094, spi_miso",
                       {glb_4094_clk, glb_4094_data, glb_4094_strobe, oe_4094, spi_miso}, 0);
    tick(4);
    chk_pattern = 1'b1;
    tick(300);
    chk_pattern = 1'b0;

    // scratch register write and readback
    repeat (3)
    begin
      lcg_state = lcg_next(lcg_state);
      wr_data   = lcg_state[31:8];
      write_reg(spi_reg_pkg::ADDR_SCRATCH, wr_data);
      read_reg(spi_reg_pkg::ADDR_SCRATCH, 24'h0, rd_data);
      assert (rd_data == wr_data) else value_error("scratch readback", rd_data, wr_data);
    end
    read_reg(7'd3, 24'h0, rd_data);
    assert (rd_data == 24'h0) else value_error("unmapped readback", rd_data, 0);
    read_reg(spi_reg_pkg::ADDR_SCRATCH, ~wr_data, rd_data);
    read_reg(spi_reg_pkg::ADDR_SCRATCH, 24'h0, rd_data);
    assert (rd_data == wr_data) else value_error("scratch after read", rd_data, wr_data);

    // all-off, then the raw counter
    write_reg(spi_reg_pkg::ADDR_MODE, 24'(cond_pkg::MODE_OFF));
    chk_off = 1'b1;
    tick(40);
    chk_off = 1'b0;
    write_reg(spi_reg_pkg::ADDR_MODE, 24'(cond_pkg::MODE_COUNTER));
    chk_counter = 1'b1;
    tick(100);
    chk_counter = 1'b0;

    // accumulation cap, first run only aligns to a phase edge
    write_reg(spi_reg_pkg::ADDR_MODE, 24'(cond_pkg::MODE_ACCUM_CAP));
    tick(2 * ACCUM_CYCLES);
    chk_accum = 1'b1;
    measure_run(run_len, code);
    repeat (4)
    begin
      measure_run(run_len, code);
      assert (run_len == ACCUM_CYCLES) else value_error("u402_ctl run length", run_len, 16);
    end
    chk_accum = 1'b0;

    // cs2 traffic with routing off stays off the chain
    chk_route_off = 1'b1;
    spi_cs2_n     = 1'b0;
    drive_chain_pins(40);
    spi_cs2_n = 1'b1;
    spi_sck   = 1'b0;
    spi_mosi  = 1'b0;
    tick(4);
    chk_route_off = 1'b0;

    // routing on, pins pass through after the synchronizer
    write_reg(spi_reg_pkg::ADDR_SPI_ROUTE, 24'h1);
    spi_cs2_n = 1'b0;
    tick(4);
    chk_route_on = 1'b1;
    drive_chain_pins(60);
    chk_route_on = 1'b0;
    spi_cs2_n    = 1'b1;
    spi_sck      = 1'b0;
    spi_mosi     = 1'b0;
    tick(4);

    // 4094 output enable
    write_reg(spi_reg_pkg::ADDR_4094, 24'h1);
    assert (oe_4094 == 1'b1) else value_error("oe_4094", oe_4094, 1);
    write_reg(spi_reg_pkg::ADDR_4094, 24'h0);
    assert (oe_4094 == 1'b0) else value_error("oe_4094", oe_4094, 0);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* dmm_ctrl_top.sv */
////////////////////////////////////////
// dmm front end control, single clk domain
// mux pins are en, a2, a1, a0 from msb
// ACCUM_PHASE_CYCLES sets each cap test phase
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cond_defs.svh"

module dmm_ctrl_top #(
  parameter int ACCUM_PHASE_CYCLES = `ACCUM_PHASE_CYCLES
) (
  input  wire        clk,
  input  wire        reset,
  // mcu spi
  input  wire        spi_sck,
  input  wire        spi_cs_n,
  input  wire        spi_cs2_n,
  input  wire        spi_mosi,
  output logic       spi_miso,
  // 4094 chain
  input  wire        u1004_4094_data,
  output logic       glb_4094_clk,
  output logic       glb_4094_data,
  output logic       glb_4094_strobe,
  output logic       oe_4094,
  // conditioning
  output logic [7:0] mon,
  output logic       led0,
  output logic       sig_pc_sw_ctl,
  output logic [3:0] u402_ctl,
  output logic [3:0] u413_ctl,
  output logic [3:0] u414_ctl
);

  cond_pkg::cond_mode_e mode;
  cond_pkg::cond_out_t  test_pattern_out;
  cond_pkg::cond_out_t  accum_out;
  cond_pkg::cond_out_t  cond_out;

  spi_control_port u_spi_control_port (
    .clk             (clk),
    .reset           (reset),
    .spi_sck         (spi_sck),
    .spi_cs_n        (spi_cs_n),
    .spi_cs2_n       (spi_cs2_n),
    .spi_mosi        (spi_mosi),
    .u1004_4094_data (u1004_4094_data),
    .spi_miso        (spi_miso),
    .glb_4094_clk    (glb_4094_clk),
    .glb_4094_data   (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe),
    .oe_4094         (oe_4094),
    .mode            (mode)
  );

  test_pattern u_test_pattern (
    .clk     (clk),
    .reset   (reset),
    .pattern (test_pattern_out)
  );

  accum_cap_sequencer #(
    .PHASE_CYCLES (ACCUM_PHASE_CYCLES)
  ) u_accum_cap_sequencer (
    .clk     (clk),
    .reset   (reset),
    .pattern (accum_out)
  );

  cond_source_select u_cond_source_select (
    .clk             (clk),
    .reset           (reset),
    .mode            (mode),
    .test_pattern_in (test_pattern_out),
    .accum_in        (accum_out),
    .cond_out        (cond_out)
  );

  // fields out to the board pins
  assign mon           = cond_out.monitor;
  assign led0          = cond_out.led;
  assign sig_pc_sw_ctl = cond_out.pc_sw;
  // u402 himux2, u413 himux, u414 azmux
  assign u402_ctl      = cond_out.himux2;
  assign u413_ctl      = cond_out.himux;
  assign u414_ctl      = cond_out.azmux;

endmodule

`default_nettype wire

/* cond_source_select.sv */
////////////////////////////////////////
// picks the pattern source for the conditioning pins
// output is registered, one clk behind the source
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cond_defs.svh"

module cond_source_select (
  input  wire                  clk,
  input  wire                  reset,
  input  wire cond_pkg::cond_mode_e mode,
  input  wire cond_pkg::cond_out_t  test_pattern_in,
  input  wire cond_pkg::cond_out_t  accum_in,
  output cond_pkg::cond_out_t  cond_out
);

  logic [`COND_NUM_BITS-1:0] counter;
  cond_pkg::cond_out_t       selected;

  // raw counter source, spans the whole vector
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      counter <= '0;
    else
      counter <= counter + 1'b1;
  end

  always_comb
  begin
    case (mode)
      cond_pkg::MODE_TEST_PATTERN: selected = test_pattern_in;
      cond_pkg::MODE_OFF:          selected = '0;
      cond_pkg::MODE_COUNTER:      selected = cond_pkg::cond_out_t'(counter);
      cond_pkg::MODE_ACCUM_CAP:    selected = accum_in;
      default:                     selected = '0;
    endcase
  end

  // all switches open while in reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      cond_out <= '0;
    else
      cond_out <= selected;
  end

endmodule

`default_nettype wire

/* accum_cap_sequencer.sv */
////////////////////////////////////////
// accumulation cap test, discharge then charge, repeating
// each phase lasts PHASE_CYCLES clk, PHASE_CYCLES >= 1
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cond_defs.svh"

module accum_cap_sequencer #(
  parameter int PHASE_CYCLES = `ACCUM_PHASE_CYCLES
) (
  input  wire                 clk,
  input  wire                 reset,
  output cond_pkg::cond_out_t pattern
);

  localparam int CNT_BITS = $clog2(2 * PHASE_CYCLES);
  localparam logic [CNT_BITS-1:0] CNT_LAST   = CNT_BITS'(2 * PHASE_CYCLES - 1);
  localparam logic [CNT_BITS-1:0] CNT_CHARGE = CNT_BITS'(PHASE_CYCLES);

  // s2, himux takes the himux2 output
  localparam logic [3:0] HIMUX_S2   = 4'b1001;
  // s4, ground to clear charge on the cap
  localparam logic [3:0] HIMUX2_GND = 4'b1011;
  // s1, dcv source hi
  localparam logic [3:0] HIMUX2_DCV = 4'b1000;

  localparam cond_pkg::cond_out_t DISCHARGE_STATE = '{
    monitor: 8'h00, led: 1'b0, pc_sw: 1'b0,
    himux2: HIMUX2_GND, himux: HIMUX_S2, azmux: 4'b0000
  };
  localparam cond_pkg::cond_out_t CHARGE_STATE = '{
    monitor: 8'h00, led: 1'b1, pc_sw: 1'b0,
    himux2: HIMUX2_DCV, himux: HIMUX_S2, azmux: 4'b0000
  };

  logic [CNT_BITS-1:0] count;
  logic                charge;

  // position within one full period
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      count <= '0;
    else if (count == CNT_LAST)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  // second half of the period connects the source
  assign charge = (count >= CNT_CHARGE);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pattern <= DISCHARGE_STATE;
    else
      pattern <= charge ? CHARGE_STATE : DISCHARGE_STATE;
  end

endmodule

`default_nettype wire

/* test_pattern.sv */
////////////////////////////////////////
// free-running pattern for bring-up
// all mux controls stay off
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cond_defs.svh"

module test_pattern (
  input  wire                 clk,
  input  wire                 reset,
  output cond_pkg::cond_out_t pattern
);

  logic [31:0] counter;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      counter <= '0;
    else
      counter <= counter + 1'b1;
  end

  // monitor counts every clk, led blinks off a high bit
  always_comb
  begin
    pattern         = '0;
    pattern.monitor = counter[7:0];
    pattern.led     = counter[`TEST_PATTERN_LED_SHIFT];
  end

endmodule

`default_nettype wire

/* spi_control_port.sv */
////////////////////////////////////////
// spi mode 0 slave, pins oversampled by clk
// sck must stay well below clk/4 for clean edge detect
// writes land only on frames of exactly 32 bits
// 4094 pass-through uses the synchronized pins
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cond_defs.svh"

module spi_control_port (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  spi_sck,
  input  wire                  spi_cs_n,
  input  wire                  spi_cs2_n,
  input  wire                  spi_mosi,
  input  wire                  u1004_4094_data,
  output logic                 spi_miso,
  output logic                 glb_4094_clk,
  output logic                 glb_4094_data,
  output logic                 glb_4094_strobe,
  output logic                 oe_4094,
  output cond_pkg::cond_mode_e mode
);

  // raw spi pins, sampled together
  typedef struct packed {
    logic sck;
    logic cs_n;
    logic cs2_n;
    logic mosi;
  } spi_pins_t;

  // idle bus, both selects released
  localparam spi_pins_t PINS_IDLE = '{sck: 1'b0, cs_n: 1'b1, cs2_n: 1'b1, mosi: 1'b0};
  // one spare bit so overlong frames saturate above 32
  localparam int CNT_BITS = $clog2(`SPI_FRAME_BITS) + 1;
  localparam logic [CNT_BITS-1:0] CNT_MAX = '1;

  spi_pins_t                  pins_meta;
  spi_pins_t                  pins_sync;
  spi_pins_t                  pins_prev;
  logic                       sck_rise;
  logic                       sck_fall;
  logic                       cs_end;
  logic [CNT_BITS-1:0]        bit_cnt;
  logic [`SPI_FRAME_BITS-1:0] rx_shift;
  logic [`SPI_DATA_BITS-1:0]  tx_shift;
  logic [`SPI_DATA_BITS-1:0]  rd_data;
  spi_reg_pkg::spi_frame_t    frame;
  spi_reg_pkg::spi_addr_e     rd_addr;
  logic [`SPI_DATA_BITS-1:0]  reg_scratch;
  logic                       reg_route;
  logic                       route_active;

  ////////////////////////////////////////
  // input sync and edge detect

  // two flops into clk domain, third for edges
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pins_meta <= PINS_IDLE;
      pins_sync <= PINS_IDLE;
      pins_prev <= PINS_IDLE;
    end
    else
    begin
      pins_meta <= '{sck: spi_sck, cs_n: spi_cs_n, cs2_n: spi_cs2_n, mosi: spi_mosi};
      pins_sync <= pins_meta;
      pins_prev <= pins_sync;
    end
  end

  assign sck_rise = pins_sync.sck & ~pins_prev.sck;
  assign sck_fall = ~pins_sync.sck & pins_prev.sck;
  // frame closes on chip select release
  assign cs_end   = pins_sync.cs_n & ~pins_prev.cs_n;

  ////////////////////////////////////////
  // frame receive

  // mosi sampled on sck rise
  always_ff @(posedge clk)
  begin
    if (sck_rise && !pins_sync.cs_n)
      rx_shift <= {rx_shift[`SPI_FRAME_BITS-2:0], pins_sync.mosi};
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_cnt <= '0;
    else if (pins_sync.cs_n)
      bit_cnt <= '0;
    else if (sck_rise && bit_cnt != CNT_MAX)
      bit_cnt <= bit_cnt + 1'b1;
  end

  assign frame   = spi_reg_pkg::spi_frame_t'(rx_shift);
  // after the first byte the address sits in the low bits
  assign rd_addr = spi_reg_pkg::spi_addr_e'(rx_shift[`SPI_ADDR_BITS-2:0]);

  ////////////////////////////////////////
  // readback

  // unmapped addresses read zero
  always_comb
  begin
    rd_data = '0;
    case (rd_addr)
      spi_reg_pkg::ADDR_SCRATCH:   rd_data = reg_scratch;
      spi_reg_pkg::ADDR_SPI_ROUTE: rd_data[0] = reg_route;
      spi_reg_pkg::ADDR_4094:      rd_data[0] = oe_4094;
      spi_reg_pkg::ADDR_MODE:      rd_data[1:0] = mode;
      default:                     rd_data = '0;
    endcase
  end

  // load on the fall after bit 8, so the mcu sees data msb on rise 9
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      tx_shift <= '0;
    else if (pins_sync.cs_n)
      tx_shift <= '0;
    else if (sck_fall)
    begin
      if (bit_cnt == CNT_BITS'(`SPI_ADDR_BITS))
        tx_shift <= rd_data;
      else
        tx_shift <= {tx_shift[`SPI_DATA_BITS-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////
  // register file

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      reg_scratch <= '0;
      reg_route   <= 1'b0;
      oe_4094     <= 1'b0;
      mode        <= cond_pkg::MODE_TEST_PATTERN;
    end
    else if (cs_end && bit_cnt == CNT_BITS'(`SPI_FRAME_BITS) && !frame.read_only)
    begin
      case (spi_reg_pkg::spi_addr_e'(frame.addr))
        spi_reg_pkg::ADDR_SCRATCH:   reg_scratch <= frame.data;
        spi_reg_pkg::ADDR_SPI_ROUTE: reg_route <= frame.data[0];
        spi_reg_pkg::ADDR_4094:      oe_4094 <= frame.data[0];
        spi_reg_pkg::ADDR_MODE:      mode <= cond_pkg::cond_mode_e'(frame.data[1:0]);
        default:                     ;
      endcase
    end
  end

  ////////////////////////////////////////
  // 4094 routing

  // cs2 only reaches the chain when route bit is set
  assign route_active    = reg_route & ~pins_sync.cs2_n;
  assign glb_4094_clk    = route_active & pins_sync.sck;
  assign glb_4094_data   = route_active & pins_sync.mosi;
  // strobe held high so the 4094 latches follow the shift stage
  assign glb_4094_strobe = route_active;

  // chain readback wins, port readback only under cs
  assign spi_miso = route_active ? u1004_4094_data :
                    (!pins_sync.cs_n ? tx_shift[`SPI_DATA_BITS-1] : 1'b0);

endmodule

`default_nettype wire

/* spi_reg_pkg.sv */
////////////////////////////////////////
// spi frame layout and register map
// addresses are 7 bits, msb of the first byte marks a read
////////////////////////////////////////

`default_nettype none

package spi_reg_pkg;

  // frame as seen after all 32 bits are in, msb first on the wire
  typedef struct packed {
    // set for a pure readback, no write at chip select end
    logic        read_only;
    logic [6:0]  addr;
    logic [23:0] data;
  } spi_frame_t;

  // register map
  typedef enum logic [6:0] {
    // 24 bit readback test register
    ADDR_SCRATCH   = 7'd7,
    // bit 0 routes cs2 traffic to the 4094 chain
    ADDR_SPI_ROUTE = 7'd8,
    // bit 0 is the 4094 output enable
    ADDR_4094      = 7'd9,
    ADDR_MODE      = 7'd12
  } spi_addr_e;

endpackage

`default_nettype wire

/* cond_pkg.sv */
////////////////////////////////////////
// types for the conditioning output vector
// field order must match the pin mapping in the top level
////////////////////////////////////////

`default_nettype none

package cond_pkg;

  // one vector drives every conditioning pin
  // mux fields are en, a2, a1, a0 from msb
  typedef struct packed {
    // monitor header, debug only
    logic [7:0] monitor;
    logic       led;
    // pre-charge switch
    logic       pc_sw;
    // u402
    logic [3:0] himux2;
    // u413
    logic [3:0] himux;
    // u414
    logic [3:0] azmux;
  } cond_out_t;

  // pattern source written by the mcu
  typedef enum logic [1:0] {
    MODE_TEST_PATTERN = 2'd0,
    MODE_OFF          = 2'd1,
    MODE_COUNTER      = 2'd2,
    MODE_ACCUM_CAP    = 2'd3
  } cond_mode_e;

endpackage

`default_nettype wire

/* cond_defs.svh */
////////////////////////////////////////
// widths and default timing shared by the conditioning rtl
// phase length assumes the 20 MHz board clock
// spi frame is fixed at 32 bits, msb first
////////////////////////////////////////

`ifndef COND_DEFS_SVH
`define COND_DEFS_SVH

// conditioning vector, monitor down to azmux
`define COND_NUM_BITS 22

// one spi frame is address then data
`define SPI_FRAME_BITS 32
`define SPI_ADDR_BITS 8
`define SPI_DATA_BITS 24

// one second per phase at 20 MHz
`define ACCUM_PHASE_CYCLES 20000000

// counter bit that blinks the led in the test pattern
`define TEST_PATTERN_LED_SHIFT 22

`endif
